/* design/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath and address width
`define RV_XLEN 32

// Integer register file
`define RV_NUM_REGS 32
`define RV_REG_AW 5

`define RV_RESET_PC 32'h0000_0000
`define RV_INSTR_BYTES 4 // PC step, no compressed instructions

`endif

/* design/rv_core.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
	input  logic clk,
	input  logic rst,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic dmem_we,
	input  logic [31:0] dmem_rdata
);
	rv_pkg::ctrl_t ctrl_d, ctrl_e;
	logic [`RV_XLEN-1:0] pc_d, imm_d, rs1_val_d, rs2_val_d;
	logic [`RV_REG_AW-1:0] rs1_d, rs2_d, rd_d;
	logic [`RV_XLEN-1:0] alu_result_e, store_data_e, pc_plus4_e, target_e;
	logic redirect_e;
	logic [`RV_XLEN-1:0] alu_result_m, result_w;

	rv_hazard_if hz ();

	rv_fetch u_fetch (
		.clk(clk), .rst(rst), .hz(hz),
		.redirect_e(redirect_e), .target_e(target_e),
		.pc_f(imem_addr) // PC drives the instruction port directly
	);

	rv_decode u_decode (
		.clk(clk), .rst(rst), .hz(hz),
		.pc_f(imem_addr), .instr_f(imem_data),
		.pc_d(pc_d), .imm_d(imm_d), .rd_d(rd_d), .ctrl_d(ctrl_d),
		.rs1_d(rs1_d), .rs2_d(rs2_d)
	);

	rv_regfile u_regfile (
		.clk(clk), .rs1(rs1_d), .rs2(rs2_d),
		.rd(hz.rd_w), .write_en(hz.reg_write_w), .write_data(result_w),
		.rs1_val(rs1_val_d), .rs2_val(rs2_val_d)
	);

	rv_execute u_execute (
		.clk(clk), .rst(rst), .hz(hz), .ctrl_d(ctrl_d),
		.pc_d(pc_d), .imm_d(imm_d), .rs1_val_d(rs1_val_d), .rs2_val_d(rs2_val_d),
		.rs1_d(rs1_d), .rs2_d(rs2_d), .rd_d(rd_d),
		.alu_result_m(alu_result_m), .result_w(result_w),
		.ctrl_e(ctrl_e), .alu_result_e(alu_result_e), .store_data_e(store_data_e),
		.pc_plus4_e(pc_plus4_e), .target_e(target_e), .redirect_e(redirect_e)
	);

	rv_mem_wb u_mem_wb (
		.clk(clk), .rst(rst), .hz(hz), .ctrl_e(ctrl_e),
		.alu_result_e(alu_result_e), .store_data_e(store_data_e),
		.pc_plus4_e(pc_plus4_e), .rd_e(hz.rd_e),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata),
		.alu_result_m(alu_result_m), .result_w(result_w)
	);

	rv_hazard u_hazard (.hz(hz));

endmodule

/* design/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode (
	input  logic clk,
	input  logic rst,
	rv_hazard_if.decode hz,
	input  logic [`RV_XLEN-1:0] pc_f,
	input  logic [`RV_XLEN-1:0] instr_f,
	output logic [`RV_XLEN-1:0] pc_d,
	output logic [`RV_XLEN-1:0] imm_d,
	output logic [`RV_REG_AW-1:0] rd_d,
	output rv_pkg::ctrl_t ctrl_d,
	output logic [`RV_REG_AW-1:0] rs1_d,
	output logic [`RV_REG_AW-1:0] rs2_d
);
	logic [`RV_XLEN-1:0] instr_q;
	rv_pkg::imm_sel_e imm_sel;

	// Fetch/decode register, all-zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (rst || hz.flush_d) begin
			instr_q <= '0;
			pc_d <= '0;
		end else if (!hz.stall_d) begin
			instr_q <= instr_f;
			pc_d <= pc_f;
		end
	end

	assign rs1_d = instr_q[19:15];
	assign rs2_d = instr_q[24:20];
	assign rd_d = instr_q[11:7];
	assign hz.rs1_d = rs1_d;
	assign hz.rs2_d = rs2_d;

	// Main and ALU decoders
	always_comb begin
		ctrl_d = '0; // Unknown opcode writes nothing
		imm_sel = rv_pkg::IMM_I;
		case (instr_q[6:0])
			rv_pkg::OP_LOAD: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.alu_src = 1'b1;
				ctrl_d.result_sel = rv_pkg::RES_LOAD;
			end
			rv_pkg::OP_STORE: begin
				ctrl_d.mem_write = 1'b1;
				ctrl_d.alu_src = 1'b1;
				imm_sel = rv_pkg::IMM_S;
			end
			rv_pkg::OP_OP: begin
				ctrl_d.reg_write = 1'b1;
				case (instr_q[14:12])
					3'b000: ctrl_d.alu_op = instr_q[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
					3'b010: ctrl_d.alu_op = rv_pkg::ALU_SLT;
					3'b110: ctrl_d.alu_op = rv_pkg::ALU_OR;
					3'b111: ctrl_d.alu_op = rv_pkg::ALU_AND;
					default: ctrl_d.alu_op = rv_pkg::ALU_ADD;
				endcase
			end
			rv_pkg::OP_OP_IMM: begin // addi only
				ctrl_d.reg_write = 1'b1;
				ctrl_d.alu_src = 1'b1;
			end
			rv_pkg::OP_BRANCH: begin
				ctrl_d.branch = 1'b1;
				ctrl_d.alu_op = rv_pkg::ALU_SUB;
				imm_sel = rv_pkg::IMM_B;
			end
			rv_pkg::OP_JAL: begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.jump = 1'b1;
				ctrl_d.result_sel = rv_pkg::RES_PC4; // Link value
				imm_sel = rv_pkg::IMM_J;
			end
			default: ;
		endcase
	end

	// Sign-extended immediates
	always_comb begin
		case (imm_sel)
			rv_pkg::IMM_S: imm_d = {{(`RV_XLEN-12){instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
			rv_pkg::IMM_B: imm_d = {{(`RV_XLEN-12){instr_q[31]}}, instr_q[7], instr_q[30:25],
				instr_q[11:8], 1'b0};
			rv_pkg::IMM_J: imm_d = {{(`RV_XLEN-20){instr_q[31]}}, instr_q[19:12], instr_q[20],
				instr_q[30:21], 1'b0};
			default: imm_d = {{(`RV_XLEN-12){instr_q[31]}}, instr_q[31:20]};
		endcase
	end

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute (
	input  logic clk,
	input  logic rst,
	rv_hazard_if.execute hz,
	input  rv_pkg::ctrl_t ctrl_d,
	input  logic [`RV_XLEN-1:0] pc_d,
	input  logic [`RV_XLEN-1:0] imm_d,
	input  logic [`RV_XLEN-1:0] rs1_val_d,
	input  logic [`RV_XLEN-1:0] rs2_val_d,
	input  logic [`RV_REG_AW-1:0] rs1_d,
	input  logic [`RV_REG_AW-1:0] rs2_d,
	input  logic [`RV_REG_AW-1:0] rd_d,
	input  logic [`RV_XLEN-1:0] alu_result_m,
	input  logic [`RV_XLEN-1:0] result_w,
	output rv_pkg::ctrl_t ctrl_e,
	output logic [`RV_XLEN-1:0] alu_result_e,
	output logic [`RV_XLEN-1:0] store_data_e,
	output logic [`RV_XLEN-1:0] pc_plus4_e,
	output logic [`RV_XLEN-1:0] target_e,
	output logic redirect_e
);
	logic [`RV_XLEN-1:0] pc_q, imm_q, rs1_val_q, rs2_val_q;
	logic [`RV_REG_AW-1:0] rs1_q, rs2_q, rd_q;
	logic [`RV_XLEN-1:0] src_a, src_b;

	// Decode/execute register, a flush leaves a bubble
	always_ff @(posedge clk) begin
		if (rst || hz.flush_e)
			ctrl_e <= '0;
		else
			ctrl_e <= ctrl_d;
	end

	always_ff @(posedge clk) begin
		pc_q <= pc_d;
		imm_q <= imm_d;
		rs1_val_q <= rs1_val_d;
		rs2_val_q <= rs2_val_d;
		rs1_q <= rs1_d;
		rs2_q <= rs2_d;
		rd_q <= rd_d;
	end

	assign hz.rs1_e = rs1_q;
	assign hz.rs2_e = rs2_q;
	assign hz.rd_e = rd_q;
	assign hz.load_e = (ctrl_e.result_sel == rv_pkg::RES_LOAD);
	assign hz.redirect_e = redirect_e;

	// Operand forwarding
	always_comb begin
		case (hz.fwd_a)
			rv_pkg::FWD_MEM: src_a = alu_result_m;
			rv_pkg::FWD_WB:  src_a = result_w;
			default:         src_a = rs1_val_q;
		endcase
		case (hz.fwd_b)
			rv_pkg::FWD_MEM: store_data_e = alu_result_m;
			rv_pkg::FWD_WB:  store_data_e = result_w;
			default:         store_data_e = rs2_val_q;
		endcase
	end

	assign src_b = ctrl_e.alu_src ? imm_q : store_data_e;

	always_comb begin
		case (ctrl_e.alu_op)
			rv_pkg::ALU_SUB: alu_result_e = src_a - src_b;
			rv_pkg::ALU_AND: alu_result_e = src_a & src_b;
			rv_pkg::ALU_OR:  alu_result_e = src_a | src_b;
			rv_pkg::ALU_SLT: alu_result_e = {{(`RV_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			default:         alu_result_e = src_a + src_b;
		endcase
	end

	assign target_e = pc_q + imm_q; // Shared by beq and jal
	assign pc_plus4_e = pc_q + `RV_INSTR_BYTES;
	assign redirect_e = ctrl_e.jump || (ctrl_e.branch && (src_a == store_data_e));

endmodule

/* design/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_fetch (
	input  logic clk,
	input  logic rst,
	rv_hazard_if.fetch hz,
	input  logic redirect_e,
	input  logic [`RV_XLEN-1:0] target_e,
	output logic [`RV_XLEN-1:0] pc_f
);
	logic [`RV_XLEN-1:0] pc_next;

	// Taken branch or jump overrides sequential fetch
	always_comb begin
		if (redirect_e)
			pc_next = target_e;
		else
			pc_next = pc_f + `RV_INSTR_BYTES;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc_f <= `RV_RESET_PC;
		else if (!hz.stall_f) // Hold during load-use bubble
			pc_f <= pc_next;
	end

endmodule

/* design/rv_hazard.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_hazard (
	rv_hazard_if.hazard hz
);
	logic load_use;

	// Newest producer wins, x0 is never forwarded
	always_comb begin
		if (hz.reg_write_m && hz.rd_m != '0 && hz.rd_m == hz.rs1_e)
			hz.fwd_a = rv_pkg::FWD_MEM;
		else if (hz.reg_write_w && hz.rd_w != '0 && hz.rd_w == hz.rs1_e)
			hz.fwd_a = rv_pkg::FWD_WB;
		else
			hz.fwd_a = rv_pkg::FWD_REG;

		if (hz.reg_write_m && hz.rd_m != '0 && hz.rd_m == hz.rs2_e)
			hz.fwd_b = rv_pkg::FWD_MEM;
		else if (hz.reg_write_w && hz.rd_w != '0 && hz.rd_w == hz.rs2_e)
			hz.fwd_b = rv_pkg::FWD_WB;
		else
			hz.fwd_b = rv_pkg::FWD_REG;
	end

	// Load data not ready until writeback, so hold one cycle
	assign load_use = hz.load_e && (hz.rd_e != '0) &&
		((hz.rd_e == hz.rs1_d) || (hz.rd_e == hz.rs2_d));

	assign hz.stall_f = load_use;
	assign hz.stall_d = load_use;
	assign hz.flush_d = hz.redirect_e; // Drop wrong-path fetch
	assign hz.flush_e = load_use || hz.redirect_e;

endmodule

/* design/rv_hazard_if.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

interface rv_hazard_if;
	logic [`RV_REG_AW-1:0] rs1_d, rs2_d;
	logic [`RV_REG_AW-1:0] rs1_e, rs2_e, rd_e;
	logic load_e, redirect_e;
	logic [`RV_REG_AW-1:0] rd_m, rd_w;
	logic reg_write_m, reg_write_w;
	logic stall_f, stall_d, flush_d, flush_e;
	rv_pkg::fwd_sel_e fwd_a, fwd_b;

	modport hazard (
		output stall_f, stall_d, flush_d, flush_e, fwd_a, fwd_b,
		input  rs1_d, rs2_d, rs1_e, rs2_e, rd_e, load_e, redirect_e,
		input  rd_m, reg_write_m, rd_w, reg_write_w
	);
	modport fetch (input stall_f);
	modport decode (output rs1_d, rs2_d, input stall_d, flush_d);
	modport execute (output rs1_e, rs2_e, rd_e, load_e, redirect_e, input flush_e, fwd_a, fwd_b);
	modport mem_wb (output rd_m, reg_write_m, rd_w, reg_write_w);
endinterface

/* design/rv_mem_wb.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_mem_wb (
	input  logic clk,
	input  logic rst,
	rv_hazard_if.mem_wb hz,
	input  rv_pkg::ctrl_t ctrl_e,
	input  logic [`RV_XLEN-1:0] alu_result_e,
	input  logic [`RV_XLEN-1:0] store_data_e,
	input  logic [`RV_XLEN-1:0] pc_plus4_e,
	input  logic [`RV_REG_AW-1:0] rd_e,
	output logic [`RV_XLEN-1:0] dmem_addr,
	output logic [`RV_XLEN-1:0] dmem_wdata,
	output logic dmem_we,
	input  logic [`RV_XLEN-1:0] dmem_rdata,
	output logic [`RV_XLEN-1:0] alu_result_m,
	output logic [`RV_XLEN-1:0] result_w
);
	logic reg_write_m, mem_write_m, reg_write_w;
	rv_pkg::result_sel_e result_sel_m, result_sel_w;
	logic [`RV_REG_AW-1:0] rd_m, rd_w;
	logic [`RV_XLEN-1:0] store_data_m, pc_plus4_m;
	logic [`RV_XLEN-1:0] alu_result_w, load_data_w, pc_plus4_w;

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_write_m <= 1'b0;
			mem_write_m <= 1'b0;
			result_sel_m <= rv_pkg::RES_ALU;
			reg_write_w <= 1'b0;
			result_sel_w <= rv_pkg::RES_ALU;
		end else begin
			reg_write_m <= ctrl_e.reg_write;
			mem_write_m <= ctrl_e.mem_write;
			result_sel_m <= ctrl_e.result_sel;
			reg_write_w <= reg_write_m;
			result_sel_w <= result_sel_m;
		end
	end

	always_ff @(posedge clk) begin
		rd_m <= rd_e;
		alu_result_m <= alu_result_e;
		store_data_m <= store_data_e;
		pc_plus4_m <= pc_plus4_e;
		rd_w <= rd_m;
		alu_result_w <= alu_result_m;
		load_data_w <= dmem_rdata; // Memory answers in the same cycle
		pc_plus4_w <= pc_plus4_m;
	end

	assign dmem_addr = alu_result_m;
	assign dmem_wdata = store_data_m;
	assign dmem_we = mem_write_m;

	assign hz.rd_m = rd_m;
	assign hz.reg_write_m = reg_write_m;
	assign hz.rd_w = rd_w;
	assign hz.reg_write_w = reg_write_w;

	always_comb begin
		case (result_sel_w)
			rv_pkg::RES_LOAD: result_w = load_data_w;
			rv_pkg::RES_PC4:  result_w = pc_plus4_w;
			default:          result_w = alu_result_w;
		endcase
	end

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_OP     = 7'b0110011,
		OP_OP_IMM = 7'b0010011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'b000,
		ALU_SUB = 3'b001,
		ALU_AND = 3'b010,
		ALU_OR  = 3'b011,
		ALU_SLT = 3'b101 // Signed compare
	} alu_op_e;

	typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} imm_sel_e;

	typedef enum logic [1:0] {RES_ALU, RES_LOAD, RES_PC4} result_sel_e;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB  = 2'b01,
		FWD_MEM = 2'b10
	} fwd_sel_e;

	typedef struct packed {
		logic        reg_write;
		logic        mem_write;
		logic        branch;
		logic        jump;
		logic        alu_src; // Immediate as second operand
		result_sel_e result_sel;
		alu_op_e     alu_op;
	} ctrl_t;

endpackage

/* design/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile (
	input  logic clk,
	input  logic [`RV_REG_AW-1:0] rs1,
	input  logic [`RV_REG_AW-1:0] rs2,
	input  logic [`RV_REG_AW-1:0] rd,
	input  logic write_en,
	input  logic [`RV_XLEN-1:0] write_data,
	output logic [`RV_XLEN-1:0] rs1_val,
	output logic [`RV_XLEN-1:0] rs2_val
);
	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];
	logic wr_live; // Write this cycle to a real register

	assign wr_live = write_en && (rd != '0);

	always_ff @(posedge clk) begin
		if (wr_live)
			regs[rd] <= write_data;
	end

	// Writeback in the same cycle is visible to decode
	assign rs1_val = (rs1 == '0) ? '0 : (wr_live && rd == rs1) ? write_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : (wr_live && rd == rs2) ? write_data : regs[rs2];

endmodule

/* list.f */
+incdir+design
design/rv_pkg.sv
design/rv_hazard_if.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_mem_wb.sv
design/rv_hazard.sv
design/rv_core.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module rv_core_tb -Mdir obj_dir -o rv_core_sim -f list.f

./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

/* tests/rv_core_assertions.sv */
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_assertions (
	input logic clk,
	input logic rst,
	input logic [31:0] imem_addr,
	input logic dmem_we
);

	// No store leaves the core around reset
	we_low_in_reset: assert property (@(posedge clk) rst |-> !dmem_we)
		else $error("dmem_we high while rst is asserted");

	we_low_after_reset: assert property (@(posedge clk) rst |=> !dmem_we)
		else $error("dmem_we high on the cycle after reset");

	pc_word_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
		else $error("imem_addr %h is not word aligned", imem_addr);

	// First fetch comes from the reset vector
	pc_at_reset_vector: assert property (@(posedge clk) $fell(rst) |-> imem_addr == `RV_RESET_PC)
		else $error("imem_addr %h after reset release", imem_addr);

	we_known: assert property (@(posedge clk) !$isunknown(dmem_we))
		else $error("dmem_we is unknown");

endmodule

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
	localparam logic [31:0] done_addr = 32'h0000_00fc;

	logic clk, rst;
	logic [31:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
	logic dmem_we;
	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] preload_val, rng;
	int prog_len, preload_idx, errors, tests_run, tests_bad;

	rv_core dut (
		.clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata)
	);

	bind rv_core rv_core_assertions u_assertions (
		.clk(clk), .rst(rst), .imem_addr(imem_addr), .dmem_we(dmem_we)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	assign imem_data = imem[imem_addr[7:2]];
	assign dmem_rdata = dmem[dmem_addr[7:2]]; // Same-cycle read

	// Data memory, refilled while reset is held
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 64; i++)
				dmem[6'(i)] <= (i == preload_idx) ? preload_val : fill_word(i);
		end else if (dmem_we) begin
			dmem[dmem_addr[7:2]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic logic [31:0] fill_word(input int idx);
		return 32'hd000_0000 | 32'(idx * 4); // Tagged with the byte address
	endfunction

	// RV32I instruction encoders
	function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] sw_word(input logic [4:0] rs2, rs1, input logic [11:0] off);
		return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] beq_word(input logic [4:0] rs1, rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[6'(prog_len)] = word;
		prog_len++;
	endtask

	// Completion store, then a branch to itself
	task automatic emit_done();
		emit(sw_word(5'd0, 5'd0, done_addr[11:0]));
		emit(beq_word(5'd0, 5'd0, 13'd0));
	endtask

	task automatic begin_program();
		int i;
		for (i = 0; i < 64; i++)
			imem[6'(i)] = addi_word(5'd0, 5'd0, 12'(i * 4)); // Address-tagged nop
		@(negedge clk);
		rst = 1'b1;
		preload_idx = -1;
		prog_len = 0;
	endtask

	task automatic release_reset();
		repeat (2) @(negedge clk);
		rst = 1'b0;
	endtask

	// Wait for the done store, then one more cycle so it lands
	task automatic run_until_done(input string name);
		int cycles;
		bit seen;
		release_reset();
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < 300) begin
			@(negedge clk);
			seen = dmem_we && (dmem_addr == done_addr);
			cycles++;
		end
		@(negedge clk);
		if (!seen) begin
			$display("%s: no store to the done address within %0d cycles", name, cycles);
			errors++;
		end
	endtask

	task automatic expect_word(input string name, input logic [31:0] addr,
		input logic [31:0] exp);
		if (dmem[addr[7:2]] !== exp) begin
			$display("error %s: word at %h expected %h, actual %h",
				name, addr, exp, dmem[addr[7:2]]);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d problems", name, errors - errors_before);
		end
	endtask

	task automatic reset_and_fetch();
		int base, i;
		base = errors;
		begin_program();
		for (i = 0; i < 8; i++)
			emit(addi_word(5'(i + 1), 5'd0, 12'(i + 3))); // Independent writes
		release_reset();
		for (i = 0; i < 12; i++) begin
			if (imem_addr !== 32'(i * 4)) begin
				$display("error reset_and_fetch: imem_addr expected %h, actual %h",
					32'(i * 4), imem_addr);
				errors++;
			end
			if (dmem_we) begin
				$display("reset_and_fetch: store issued by a program without stores");
				errors++;
			end
			@(negedge clk);
		end
		finish_test("reset_and_fetch", base);
	endtask

	task automatic alu_operations();
		logic [31:0] a, b;
		int base, i;
		base = errors;
		a = sext12(12'hfdb); // Negative operand
		b = sext12(12'h5dc);
		begin_program();
		emit(addi_word(5'd1, 5'd0, 12'hfdb));
		emit(addi_word(5'd2, 5'd0, 12'h5dc));
		emit(rtype(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
		emit(rtype(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4)); // sub
		emit(rtype(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd5));
		emit(rtype(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd6));
		emit(rtype(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd7)); // slt gives one
		emit(rtype(7'b0000000, 5'd1, 5'd2, 3'b010, 5'd8)); // slt gives zero
		for (i = 3; i <= 8; i++)
			emit(sw_word(5'(i), 5'd0, 12'((i - 3) * 4)));
		emit_done();
		run_until_done("alu_operations");
		expect_word("alu_operations", 32'h00, a + b);
		expect_word("alu_operations", 32'h04, a - b);
		expect_word("alu_operations", 32'h08, a & b);
		expect_word("alu_operations", 32'h0c, a | b);
		expect_word("alu_operations", 32'h10, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		expect_word("alu_operations", 32'h14, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		finish_test("alu_operations", base);
	endtask

	task automatic forwarding_chain();
		logic [31:0] sum, first;
		int base, i;
		base = errors;
		sum = '0;
		first = '0;
		begin_program();
		emit(addi_word(5'd1, 5'd0, 12'h000));
		for (i = 0; i < 4; i++) begin
			rng = xorshift(rng);
			emit(addi_word(5'd1, 5'd1, rng[11:0]));
			sum = sum + sext12(rng[11:0]);
			if (i == 1) begin
				emit(sw_word(5'd1, 5'd0, 12'h000)); // Data from memory stage
				first = sum;
			end
		end
		emit(addi_word(5'd3, 5'd0, 12'h007));
		emit(sw_word(5'd1, 5'd0, 12'h004)); // Data from writeback
		rng = xorshift(rng);
		emit(addi_word(5'd2, 5'd1, rng[11:0]));
		emit(sw_word(5'd2, 5'd0, 12'h008));
		emit_done();
		run_until_done("forwarding_chain");
		expect_word("forwarding_chain", 32'h000, first);
		expect_word("forwarding_chain", 32'h004, sum);
		expect_word("forwarding_chain", 32'h008, sum + sext12(rng[11:0]));
		finish_test("forwarding_chain", base);
	endtask

	task automatic load_use_stall();
		int base;
		base = errors;
		rng = xorshift(rng);
		begin_program();
		preload_idx = 8;
		preload_val = rng;
		emit(addi_word(5'd2, 5'd0, 12'h123));
		emit(lw_word(5'd1, 5'd0, 12'h020));
		emit(rtype(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3)); // Needs the load at once
		emit(sw_word(5'd3, 5'd0, 12'h000));
		emit_done();
		run_until_done("load_use_stall");
		expect_word("load_use_stall", 32'h020, preload_val);
		expect_word("load_use_stall", 32'h000, preload_val + sext12(12'h123));
		finish_test("load_use_stall", base);
	endtask

	task automatic branch_skip();
		int base;
		base = errors;
		begin_program();
		emit(addi_word(5'd1, 5'd0, 12'd5));
		emit(addi_word(5'd2, 5'd0, 12'd5));
		emit(beq_word(5'd1, 5'd2, 13'd8)); // Taken over the marker store
		emit(sw_word(5'd1, 5'd0, 12'h010));
		emit(addi_word(5'd3, 5'd0, 12'd9));
		emit(beq_word(5'd1, 5'd3, 13'd8));
		emit(sw_word(5'd3, 5'd0, 12'h014));
		emit_done();
		run_until_done("branch_skip");
		expect_word("branch_skip", 32'h010, fill_word(4));
		expect_word("branch_skip", 32'h014, 32'd9);
		finish_test("branch_skip", base);
	endtask

	task automatic jump_link();
		logic [31:0] link;
		int base;
		base = errors;
		begin_program();
		emit(addi_word(5'd5, 5'd0, 12'd1));
		link = 32'(prog_len * 4) + 32'd4;
		emit(jal_word(5'd1, 21'd8));
		emit(sw_word(5'd5, 5'd0, 12'h018)); // Skipped by the jump
		emit(sw_word(5'd1, 5'd0, 12'h01c));
		emit_done();
		run_until_done("jump_link");
		expect_word("jump_link", 32'h018, fill_word(6));
		expect_word("jump_link", 32'h01c, link);
		finish_test("jump_link", base);
	endtask

	initial begin
		rst = 1'b1;
		preload_idx = -1;
		preload_val = '0;
		prog_len = 0;
		errors = 0;
		tests_run = 0;
		tests_bad = 0;
		rng = 32'h686c;
		reset_and_fetch();
		alu_operations();
		forwarding_chain();
		load_use_stall();
		branch_skip();
		jump_link();
		$display("%0d tests run, %0d with problems, %0d errors", tests_run, tests_bad, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
